//--- hdl/dac_lane_framer.sv
module dac_lane_framer (
  input logic tx_clk,
  input logic rst_n,
  input logic tx_ready,
  input dac_pkg::dac_word_t word_in,
  output logic [dac_pkg::word_w-1:0] tx_data
);

  import dac_pkg::*;

  dac_word_t framed;

  // ********************
  // lane reorder
  // ********************

  // lane l gets sample l low, sample l+8 high
  always_comb begin
    framed = '0;
    for (int l = 0; l < num_lanes; l++) begin
      framed.lanes[l] = {word_in.samples[l+num_lanes], word_in.samples[l]};
    end
  end

  // ********************
  // output register
  // ********************

  always_ff @(posedge tx_clk) begin
    if (!rst_n) begin
      tx_data <= '0;
    end else if (tx_ready) begin
      // link stalls hold the last word
      tx_data <= framed;
    end
  end

endmodule

//--- hdl/dac_pkg.sv
package dac_pkg;

  // ********************
  // up bus geometry
  // ********************

  // word address, byte address bits 15:2
  localparam int up_addr_w = 14;
  localparam int up_data_w = 32;

  // ********************
  // sample word geometry
  // ********************

  localparam int num_samples = 16;
  localparam int num_lanes = 8;
  localparam int sample_w = 16;
  localparam int word_w = num_samples * sample_w;
  // two samples per lane
  localparam int lane_w = word_w / num_lanes;

  // ********************
  // register map
  // ********************

  localparam logic [up_addr_w-1:0] reg_version = 14'd0;
  localparam logic [up_addr_w-1:0] reg_id = 14'd1;
  localparam logic [up_addr_w-1:0] reg_scratch = 14'd2;
  // bit 0 enable, bits 2:1 source select
  localparam logic [up_addr_w-1:0] reg_control = 14'd16;
  // low half even samples, high half odd samples
  localparam logic [up_addr_w-1:0] reg_pattern = 14'd17;
  // bit 0 overflow, bit 1 underflow, bit 2 datapath disabled
  localparam logic [up_addr_w-1:0] reg_status = 14'd18;

  // major.minor.patch, read only
  localparam logic [up_data_w-1:0] core_version = 32'h0001_0061;

  // data source for the transmit word
  typedef enum logic [1:0] {
    src_dma = 2'd0,
    src_pattern = 2'd1,
    src_ramp = 2'd2
  } src_sel_t;

  // one transmit word, seen as samples or as link lanes
  typedef union packed {
    logic [num_samples-1:0][sample_w-1:0] samples;
    logic [num_lanes-1:0][lane_w-1:0] lanes;
  } dac_word_t;

  typedef struct packed {
    logic wr;
    logic [up_addr_w-1:0] addr;
    logic [up_data_w-1:0] data;
  } up_wr_req_t;

  typedef struct packed {
    logic rd;
    logic [up_addr_w-1:0] addr;
  } up_rd_req_t;

  typedef struct packed {
    logic ack;
    logic [up_data_w-1:0] data;
  } up_rd_rsp_t;

  // register map to source
  typedef struct packed {
    logic enable;
    src_sel_t sel;
    logic [2*sample_w-1:0] pattern;
  } dac_ctrl_t;

endpackage

//--- hdl/dac_regmap.sv
module dac_regmap #(
  parameter logic [31:0] ID = 32'd0,
  parameter bit DATAPATH_DISABLE = 1'b0
) (
  input logic tx_clk,
  input logic rst_n,

  // up bus
  input dac_pkg::up_wr_req_t wr_req,
  input dac_pkg::up_rd_req_t rd_req,
  output logic wack,
  output dac_pkg::up_rd_rsp_t rd_rsp,

  // dma status strobes
  input logic dovf,
  input logic dunf,

  output dac_pkg::dac_ctrl_t ctrl
);

  import dac_pkg::*;

  logic [up_data_w-1:0] scratch;
  logic ovf_sticky;
  logic unf_sticky;
  logic [up_data_w-1:0] rd_mux;
  logic wr_status;

  // ********************
  // write decode
  // ********************

  assign wr_status = wr_req.wr && (wr_req.addr == reg_status);

  always_ff @(posedge tx_clk) begin
    if (!rst_n) begin
      wack <= 1'b0;
      scratch <= '0;
      ctrl.enable <= 1'b0;
      ctrl.sel <= src_dma;
      ctrl.pattern <= '0;
      ovf_sticky <= 1'b0;
      unf_sticky <= 1'b0;
    end else begin
      // ack one cycle after the strobe
      wack <= wr_req.wr;
      if (wr_req.wr) begin
        case (wr_req.addr)
          reg_scratch: scratch <= wr_req.data;
          reg_control: begin
            ctrl.enable <= wr_req.data[0];
            ctrl.sel <= src_sel_t'(wr_req.data[2:1]);
          end
          reg_pattern: ctrl.pattern <= wr_req.data;
          default: ;
        endcase
      end
      // write one clears and a new strobe wins
      ovf_sticky <= (ovf_sticky & ~(wr_status & wr_req.data[0])) | dovf;
      unf_sticky <= (unf_sticky & ~(wr_status & wr_req.data[1])) | dunf;
    end
  end

  // ********************
  // read decode
  // ********************

  always_comb begin
    rd_mux = '0;
    case (rd_req.addr)
      reg_version: rd_mux = core_version;
      reg_id: rd_mux = ID;
      reg_scratch: rd_mux = scratch;
      reg_control: rd_mux = {29'd0, ctrl.sel, ctrl.enable};
      reg_pattern: rd_mux = ctrl.pattern;
      reg_status: rd_mux = {29'd0, DATAPATH_DISABLE, unf_sticky, ovf_sticky};
      default: rd_mux = '0;
    endcase
  end

  always_ff @(posedge tx_clk) begin
    // read data lines up with the ack
    rd_rsp.data <= rd_mux;
    if (!rst_n) begin
      rd_rsp.ack <= 1'b0;
    end else begin
      rd_rsp.ack <= rd_req.rd;
    end
  end

  // one strobe at a time and exactly one ack for it on the next cycle
  assert property (@(posedge tx_clk) disable iff (!rst_n)
    (wr_req.wr || rd_req.rd) |=> !(wr_req.wr || rd_req.rd) && (wack ^ rd_rsp.ack));

endmodule

//--- hdl/dac_source.sv
module dac_source #(
  parameter bit DATAPATH_DISABLE = 1'b0
) (
  input logic tx_clk,
  input logic rst_n,
  input dac_pkg::dac_ctrl_t ctrl,
  input logic tx_ready,

  // dma side
  output logic dac_valid,
  input logic [dac_pkg::word_w-1:0] ddata,

  output dac_pkg::dac_word_t word
);

  import dac_pkg::*;

  src_sel_t sel;
  logic [sample_w-1:0] ramp_cnt;
  dac_word_t word_nxt;

  // fixed dma path when the datapath is left out
  assign sel = DATAPATH_DISABLE ? src_dma : ctrl.sel;

  // dma must present a word in these cycles
  assign dac_valid = ctrl.enable & tx_ready;

  // ********************
  // source select
  // ********************

  always_comb begin
    word_nxt = '0;
    case (sel)
      src_pattern: begin
        // even samples low half, odd samples high half
        for (int k = 0; k < num_samples; k++) begin
          word_nxt.samples[k] = k[0] ? ctrl.pattern[2*sample_w-1:sample_w]
                                     : ctrl.pattern[sample_w-1:0];
        end
      end
      src_ramp: begin
        // counter plus sample index, wraps at 16 bits
        for (int k = 0; k < num_samples; k++) begin
          word_nxt.samples[k] = ramp_cnt + sample_w'(k);
        end
      end
      default: begin
        // dma word as is
        word_nxt.samples = ddata;
      end
    endcase
  end

  // ********************
  // sample register
  // ********************

  always_ff @(posedge tx_clk) begin
    if (!rst_n) begin
      word <= '0;
      ramp_cnt <= '0;
    end else if (tx_ready) begin
      // zero out while disabled
      word <= ctrl.enable ? word_nxt : '0;
      // one step per accepted ramp word
      if (dac_valid && (sel == src_ramp)) begin
        ramp_cnt <= ramp_cnt + sample_w'(num_samples);
      end
    end
  end

endmodule

//--- hdl/dac_top.sv
module dac_top #(
  parameter logic [31:0] ID = 32'd0,
  parameter bit DATAPATH_DISABLE = 1'b0
) (
  input logic tx_clk,
  input logic rst_n,

  // link side
  output logic tx_valid,
  output logic [dac_pkg::word_w-1:0] tx_data,
  input logic tx_ready,

  // dma side
  output logic dac_valid,
  output logic dac_enable,
  input logic [dac_pkg::word_w-1:0] dac_ddata,
  input logic dac_dovf,
  input logic dac_dunf,

  // axi4-lite slave
  input logic s_axi_awvalid,
  input logic [31:0] s_axi_awaddr,
  output logic s_axi_awready,
  input logic s_axi_wvalid,
  input logic [31:0] s_axi_wdata,
  output logic s_axi_wready,
  output logic s_axi_bvalid,
  output logic [1:0] s_axi_bresp,
  input logic s_axi_bready,
  input logic s_axi_arvalid,
  input logic [31:0] s_axi_araddr,
  output logic s_axi_arready,
  output logic s_axi_rvalid,
  output logic [31:0] s_axi_rdata,
  output logic [1:0] s_axi_rresp,
  input logic s_axi_rready
);

  import dac_pkg::*;

  up_wr_req_t wr_req;
  logic wack;
  up_rd_req_t rd_req;
  up_rd_rsp_t rd_rsp;
  dac_ctrl_t ctrl;
  dac_word_t word;

  // link always sees valid data
  assign tx_valid = 1'b1;
  assign dac_enable = ctrl.enable;

  // ********************
  // register access
  // ********************

  up_axi_lite i_up_axi_lite (
    .tx_clk (tx_clk),
    .rst_n (rst_n),
    .awvalid (s_axi_awvalid),
    .awaddr (s_axi_awaddr),
    .awready (s_axi_awready),
    .wvalid (s_axi_wvalid),
    .wdata (s_axi_wdata),
    .wready (s_axi_wready),
    .bvalid (s_axi_bvalid),
    .bresp (s_axi_bresp),
    .bready (s_axi_bready),
    .arvalid (s_axi_arvalid),
    .araddr (s_axi_araddr),
    .arready (s_axi_arready),
    .rvalid (s_axi_rvalid),
    .rdata (s_axi_rdata),
    .rresp (s_axi_rresp),
    .rready (s_axi_rready),
    .wr_req (wr_req),
    .wack (wack),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp)
  );

  dac_regmap #(
    .ID (ID),
    .DATAPATH_DISABLE (DATAPATH_DISABLE)
  ) i_dac_regmap (
    .tx_clk (tx_clk),
    .rst_n (rst_n),
    .wr_req (wr_req),
    .rd_req (rd_req),
    .wack (wack),
    .rd_rsp (rd_rsp),
    .dovf (dac_dovf),
    .dunf (dac_dunf),
    .ctrl (ctrl)
  );

  // ********************
  // data path
  // ********************

  dac_source #(
    .DATAPATH_DISABLE (DATAPATH_DISABLE)
  ) i_dac_source (
    .tx_clk (tx_clk),
    .rst_n (rst_n),
    .ctrl (ctrl),
    .tx_ready (tx_ready),
    .dac_valid (dac_valid),
    .ddata (dac_ddata),
    .word (word)
  );

  dac_lane_framer i_dac_lane_framer (
    .tx_clk (tx_clk),
    .rst_n (rst_n),
    .tx_ready (tx_ready),
    .word_in (word),
    .tx_data (tx_data)
  );

endmodule

//--- hdl/up_axi_lite.sv
module up_axi_lite (
  input logic tx_clk,
  input logic rst_n,

  // axi4-lite write address and data
  input logic awvalid,
  input logic [31:0] awaddr,
  output logic awready,
  input logic wvalid,
  input logic [31:0] wdata,
  output logic wready,

  // axi4-lite write response
  output logic bvalid,
  output logic [1:0] bresp,
  input logic bready,

  // axi4-lite read
  input logic arvalid,
  input logic [31:0] araddr,
  output logic arready,
  output logic rvalid,
  output logic [31:0] rdata,
  output logic [1:0] rresp,
  input logic rready,

  // up bus
  output dac_pkg::up_wr_req_t wr_req,
  input logic wack,
  output dac_pkg::up_rd_req_t rd_req,
  input dac_pkg::up_rd_rsp_t rd_rsp
);

  import dac_pkg::*;

  // accept, issue strobe, wait ack, respond
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_req = 2'd1;
  localparam logic [1:0] st_ack = 2'd2;
  localparam logic [1:0] st_resp = 2'd3;

  logic [1:0] state;
  logic is_rd;
  logic [up_data_w-1:0] rdata_q;
  logic accept_rd;
  logic accept_wr;

  // ********************
  // channel handshakes
  // ********************

  // reads win a tie with writes
  assign accept_rd = (state == st_idle) && arvalid;
  assign accept_wr = (state == st_idle) && !arvalid && awvalid && wvalid;

  assign arready = accept_rd;
  // address and data taken together
  assign awready = accept_wr;
  assign wready = accept_wr;

  // always okay
  assign bresp = 2'b00;
  assign rresp = 2'b00;
  assign rdata = rdata_q;

  // ********************
  // transaction fsm
  // ********************

  always_ff @(posedge tx_clk) begin
    // payload registers
    if (accept_wr) begin
      // drop byte offset
      wr_req.addr <= awaddr[up_addr_w+1:2];
      wr_req.data <= wdata;
    end
    if (accept_rd) begin
      rd_req.addr <= araddr[up_addr_w+1:2];
    end
    // hold read data for the r channel
    if (rd_rsp.ack) begin
      rdata_q <= rd_rsp.data;
    end

    if (!rst_n) begin
      state <= st_idle;
      is_rd <= 1'b0;
      wr_req.wr <= 1'b0;
      rd_req.rd <= 1'b0;
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (accept_rd) begin
            rd_req.rd <= 1'b1;
            is_rd <= 1'b1;
            state <= st_req;
          end else if (accept_wr) begin
            wr_req.wr <= 1'b1;
            is_rd <= 1'b0;
            state <= st_req;
          end
        end
        st_req: begin
          // strobe is a single cycle
          wr_req.wr <= 1'b0;
          rd_req.rd <= 1'b0;
          state <= st_ack;
        end
        st_ack: begin
          if (is_rd && rd_rsp.ack) begin
            rvalid <= 1'b1;
            state <= st_resp;
          end else if (!is_rd && wack) begin
            bvalid <= 1'b1;
            state <= st_resp;
          end
        end
        default: begin
          // back-pressure keeps us here
          if (bvalid && bready) begin
            bvalid <= 1'b0;
            state <= st_idle;
          end
          if (rvalid && rready) begin
            rvalid <= 1'b0;
            state <= st_idle;
          end
        end
      endcase
    end
  end

  // no second strobe before the ack, and the response follows the ack
  assert property (@(posedge tx_clk) disable iff (!rst_n)
    (wr_req.wr || rd_req.rd) |=>
      !(wr_req.wr || rd_req.rd) ##1 (!(wr_req.wr || rd_req.rd) && (bvalid || rvalid)));

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the dac core testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_dac_top --Mdir obj_dir -o sim_dac -f sim.f \
  || { echo "build failed"; exit 1; }

./obj_dir/sim_dac > sim.log 2>&1
cat sim.log

grep -q "Errors found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "No errors" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"

//--- sim.f
hdl/dac_pkg.sv
hdl/up_axi_lite.sv
hdl/dac_regmap.sv
hdl/dac_source.sv
hdl/dac_lane_framer.sv
hdl/dac_top.sv
tests/tb_dac_top.sv

//--- tests/tb_dac_top.sv
module tb_dac_top;

  timeunit 1ns;
  timeprecision 100ps;

  import dac_pkg::*;

  localparam logic [31:0] dut_id = 32'h0000_9162;
  localparam int clk_period = 20;
  localparam int reset_cycles = 10;
  localparam int dma_cycles = 300;
  localparam int pattern_cycles = 100;
  // over 4096 words so the 16 bit ramp wraps
  localparam int ramp_words = 4200;
  localparam int reg_ops = 24;
  // stalls take at most half the cycles and a register access about 8
  localparam int test_cycles = reset_cycles + 10 * reg_ops + 100
                               + 2 * (dma_cycles + pattern_cycles + ramp_words);
  localparam int watchdog_ns = 2 * test_cycles * clk_period;

  logic tx_clk;
  logic rst_n;
  logic tx_valid;
  logic [word_w-1:0] tx_data;
  logic tx_ready;
  logic dac_valid;
  logic dac_enable;
  logic [word_w-1:0] dac_ddata;
  logic dac_dovf;
  logic dac_dunf;
  logic s_axi_awvalid;
  logic [31:0] s_axi_awaddr;
  logic s_axi_awready;
  logic s_axi_wvalid;
  logic [31:0] s_axi_wdata;
  logic s_axi_wready;
  logic s_axi_bvalid;
  logic [1:0] s_axi_bresp;
  logic s_axi_bready;
  logic s_axi_arvalid;
  logic [31:0] s_axi_araddr;
  logic s_axi_arready;
  logic s_axi_rvalid;
  logic [31:0] s_axi_rdata;
  logic [1:0] s_axi_rresp;
  logic s_axi_rready;

  // reference model state
  logic m_enable;
  logic [1:0] m_sel;
  logic [31:0] m_pattern;
  logic [15:0] m_ramp;
  logic [word_w-1:0] m_word;
  logic [word_w-1:0] exp_tx;
  logic pend_wr;
  logic [up_addr_w-1:0] pend_addr;
  logic [31:0] pend_data;
  logic [31:0] exp_rd;
  int words_accepted;
  int stall_left;

  dac_top #(
    .ID (dut_id),
    .DATAPATH_DISABLE (1'b0)
  ) i_dac_top (
    .tx_clk (tx_clk),
    .rst_n (rst_n),
    .tx_valid (tx_valid),
    .tx_data (tx_data),
    .tx_ready (tx_ready),
    .dac_valid (dac_valid),
    .dac_enable (dac_enable),
    .dac_ddata (dac_ddata),
    .dac_dovf (dac_dovf),
    .dac_dunf (dac_dunf),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awaddr (s_axi_awaddr),
    .s_axi_awready (s_axi_awready),
    .s_axi_wvalid (s_axi_wvalid),
    .s_axi_wdata (s_axi_wdata),
    .s_axi_wready (s_axi_wready),
    .s_axi_bvalid (s_axi_bvalid),
    .s_axi_bresp (s_axi_bresp),
    .s_axi_bready (s_axi_bready),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_araddr (s_axi_araddr),
    .s_axi_arready (s_axi_arready),
    .s_axi_rvalid (s_axi_rvalid),
    .s_axi_rdata (s_axi_rdata),
    .s_axi_rresp (s_axi_rresp),
    .s_axi_rready (s_axi_rready)
  );

  // ********************
  // helpers
  // ********************

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Errors found");
    $fatal(1);
  endtask

  function automatic logic [word_w-1:0] random_word();
    logic [word_w-1:0] w;
    for (int i = 0; i < word_w / 32; i++) begin
      w[32*i +: 32] = $urandom;
    end
    return w;
  endfunction

  // next source word with sample 0 in the low bits
  function automatic logic [word_w-1:0] expected_source(input logic [1:0] sel,
      input logic [31:0] pattern, input logic [15:0] ramp, input logic [word_w-1:0] dma);
    logic [word_w-1:0] w;
    w = dma;
    for (int k = 0; k < 16; k++) begin
      if (sel == src_pattern) begin
        w[16*k +: 16] = (k % 2 == 1) ? pattern[31:16] : pattern[15:0];
      end else if (sel == src_ramp) begin
        w[16*k +: 16] = ramp + 16'(k);
      end
    end
    return w;
  endfunction

  // lane l holds sample l low and sample l+8 high
  function automatic logic [word_w-1:0] frame_lanes(input logic [word_w-1:0] w);
    logic [word_w-1:0] f;
    for (int l = 0; l < 8; l++) begin
      f[32*l +: 16] = w[16*l +: 16];
      f[32*l+16 +: 16] = w[16*(l+8) +: 16];
    end
    return f;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge tx_clk);
    #2;
  endtask

  task automatic axi_write(input logic [up_addr_w-1:0] addr, input logic [31:0] data);
    s_axi_awaddr = {16'd0, addr, 2'b00};
    s_axi_wdata = data;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid = 1'b1;
    do @(posedge tx_clk); while (!s_axi_awready);
    #2;
    s_axi_awvalid = 1'b0;
    s_axi_wvalid = 1'b0;
    s_axi_bready = 1'b1;
    do @(posedge tx_clk); while (!s_axi_bvalid);
    #2;
    s_axi_bready = 1'b0;
  endtask

  // expected read data is kept in exp_rd
  task automatic axi_read_check(input logic [up_addr_w-1:0] addr, input logic [31:0] expected);
    exp_rd = expected;
    s_axi_araddr = {16'd0, addr, 2'b00};
    s_axi_arvalid = 1'b1;
    do @(posedge tx_clk); while (!s_axi_arready);
    #2;
    s_axi_arvalid = 1'b0;
    s_axi_rready = 1'b1;
    do @(posedge tx_clk); while (!s_axi_rvalid);
    #2;
    s_axi_rready = 1'b0;
  endtask

  task automatic pulse_strobes(input logic ovf, input logic unf);
    dac_dovf = ovf;
    dac_dunf = unf;
    wait_cycles(1);
    dac_dovf = 1'b0;
    dac_dunf = 1'b0;
  endtask

  // ********************
  // clock, dma and link
  // ********************

  initial begin
    tx_clk = 1'b0;
    forever begin
      #(clk_period / 2) tx_clk = ~tx_clk;
    end
  end

  // new dma word after each accepted one
  initial begin
    logic accepted;
    void'($urandom(32'haa49));
    stall_left = 0;
    words_accepted = 0;
    forever begin
      @(posedge tx_clk);
      accepted = dac_valid;
      #2;
      if (accepted === 1'b1) begin
        dac_ddata = random_word();
        words_accepted++;
      end
      // short random link stalls
      if (stall_left > 0) begin
        stall_left--;
        tx_ready = 1'b0;
      end else if ($urandom_range(0, 15) == 0) begin
        stall_left = $urandom_range(0, 2);
        tx_ready = 1'b0;
      end else begin
        tx_ready = 1'b1;
      end
    end
  end

  // ********************
  // reference model
  // ********************

  // register writes land on the edge after the aw handshake
  always @(posedge tx_clk) begin
    if (!rst_n) begin
      m_enable <= 1'b0;
      m_sel <= src_dma;
      m_pattern <= '0;
      m_ramp <= '0;
      m_word <= '0;
      exp_tx <= '0;
      pend_wr <= 1'b0;
    end else begin
      pend_wr <= s_axi_awvalid && s_axi_awready;
      pend_addr <= s_axi_awaddr[up_addr_w+1:2];
      pend_data <= s_axi_wdata;
      if (pend_wr && pend_addr == reg_control) begin
        m_enable <= pend_data[0];
        m_sel <= pend_data[2:1];
      end
      if (pend_wr && pend_addr == reg_pattern) begin
        m_pattern <= pend_data;
      end
      // both stages move only on link ready
      if (tx_ready) begin
        exp_tx <= frame_lanes(m_word);
        m_word <= m_enable ? expected_source(m_sel, m_pattern, m_ramp, dac_ddata) : '0;
        if (m_enable && m_sel == src_ramp) begin
          m_ramp <= m_ramp + 16'd16;
        end
      end
    end
  end

  // ********************
  // checks
  // ********************

  reset_idle: assert property (@(posedge tx_clk) $rose(rst_n) |->
      !dac_valid && !dac_enable && !s_axi_bvalid && !s_axi_rvalid && !s_axi_awready
      && !s_axi_wready && !s_axi_arready && (tx_data == '0))
    else stop_on_error($sformatf("CHECK FAILED at %0t ns: outputs not idle after reset", $time));

  tx_data_match: assert property (@(posedge tx_clk) disable iff (!rst_n) tx_data == exp_tx)
    else stop_on_error($sformatf("CHECK FAILED at %0t ns: tx_data %h expected %h",
                                 $time, $sampled(tx_data), $sampled(exp_tx)));

  dma_valid_match: assert property (@(posedge tx_clk) disable iff (!rst_n)
      (dac_valid == (m_enable && tx_ready)) && (dac_enable == m_enable) && tx_valid)
    else stop_on_error($sformatf("CHECK FAILED at %0t ns: dac_valid %b dac_enable %b",
                                 $time, $sampled(dac_valid), $sampled(dac_enable)));

  // address and data channels are taken in the same cycle
  aw_w_ready_pair: assert property (@(posedge tx_clk) disable iff (!rst_n)
      s_axi_awready == s_axi_wready)
    else stop_on_error($sformatf("CHECK FAILED at %0t ns: awready %b wready %b",
                                 $time, $sampled(s_axi_awready), $sampled(s_axi_wready)));

  read_data_match: assert property (@(posedge tx_clk) disable iff (!rst_n)
      s_axi_rvalid && s_axi_rready |-> (s_axi_rdata == exp_rd) && (s_axi_rresp == 2'b00))
    else stop_on_error($sformatf("CHECK FAILED at %0t ns: rdata %h expected %h",
                                 $time, $sampled(s_axi_rdata), $sampled(exp_rd)));

  write_resp_okay: assert property (@(posedge tx_clk) disable iff (!rst_n)
      s_axi_bvalid |-> s_axi_bresp == 2'b00)
    else stop_on_error($sformatf("CHECK FAILED at %0t ns: bresp not okay", $time));

  initial begin
    #(watchdog_ns);
    stop_on_error("timeout: the test sequence did not finish in the expected time");
  end

  // ********************
  // test sequence
  // ********************

  initial begin
    int start;
    rst_n = 1'b0;
    tx_ready = 1'b0;
    dac_ddata = '0;
    dac_dovf = 1'b0;
    dac_dunf = 1'b0;
    s_axi_awvalid = 1'b0;
    s_axi_awaddr = '0;
    s_axi_wvalid = 1'b0;
    s_axi_wdata = '0;
    s_axi_bready = 1'b0;
    s_axi_arvalid = 1'b0;
    s_axi_araddr = '0;
    s_axi_rready = 1'b0;
    exp_rd = '0;
    wait_cycles(reset_cycles);
    rst_n = 1'b1;
    wait_cycles(1);

    // identity and scratch
    axi_read_check(reg_version, core_version);
    axi_read_check(reg_id, dut_id);
    axi_read_check(reg_scratch, 32'd0);
    axi_write(reg_scratch, 32'h5a5a_a5a5);
    axi_read_check(reg_scratch, 32'h5a5a_a5a5);
    axi_write(reg_scratch, 32'h0123_4567);
    axi_read_check(reg_scratch, 32'h0123_4567);

    // dma source enabled
    axi_write(reg_control, 32'd1);
    wait_cycles(dma_cycles);

    // pattern source
    axi_write(reg_pattern, 32'h7fff_8001);
    axi_read_check(reg_pattern, 32'h7fff_8001);
    axi_write(reg_control, 32'd3);
    wait_cycles(pattern_cycles);

    // ramp source long enough to wrap
    axi_write(reg_control, 32'd5);
    axi_read_check(reg_control, 32'd5);
    start = words_accepted;
    while (words_accepted - start < ramp_words) begin
      wait_cycles(1);
    end

    // sticky status with write one to clear
    axi_read_check(reg_status, 32'd0);
    pulse_strobes(1'b1, 1'b0);
    axi_read_check(reg_status, 32'd1);
    pulse_strobes(1'b0, 1'b1);
    axi_read_check(reg_status, 32'd3);
    axi_write(reg_status, 32'd1);
    axi_read_check(reg_status, 32'd2);
    axi_write(reg_status, 32'd2);
    axi_read_check(reg_status, 32'd0);

    // disable and let the output fall to zero
    axi_write(reg_control, 32'd0);
    axi_read_check(reg_control, 32'd0);
    wait_cycles(20);

    $display("No errors");
    $finish;
  end

endmodule
